// ==== hw/usb_aon_timing_pkg.sv ====
// Timing constants of the always-on wake detector, imported by the filters and the pull-up hold
`default_nettype none

package usb_aon_timing_pkg;

  // Number of flops in each synchronizer that brings a pin condition or
  // a pull-up enable into the always-on clock domain
  localparam int SyncStages = 2;

  // The always-on clock is slow, so a handful of samples already covers
  // tens of microseconds of line activity
  localparam int ActivityFilterCycles = 4;

  // Bus reset and VBUS loss use a slightly shorter debounce than the
  // generic activity detector
  localparam int EventFilterCycles = 3;

  // Worst case latency from a pin change to a filtered level
  localparam int MaxFilterLatency = SyncStages + ActivityFilterCycles;

endpackage : usb_aon_timing_pkg

`default_nettype wire

// ==== hw/usb_aon_event_pkg.sv ====
// Wake event vector shared by the line monitor, the wake FSM, the top level and the checker
`default_nettype none

package usb_aon_event_pkg;

  // One bit per wake source that the detector watches while suspended
  localparam int NumWakeEvents = 3;

  // Filtered or latched events, one bit per source
  typedef logic [NumWakeEvents-1:0] aon_events_t;

  // The line left its idle level (resume K or SE0 in either orientation)
  localparam int EvNotIdle = 0;

  // Both data lines low, which the host uses for a bus reset
  localparam int EvBusReset = 1;

  // VBUS sense pin dropped, so the cable was pulled
  localparam int EvSenseLost = 2;

  // No events pending
  localparam aon_events_t NoEvents = '0;

endpackage : usb_aon_event_pkg

`default_nettype wire

// ==== hw/aon_glitch_filter.sv ====
// Synchronizes one asynchronous pin condition and passes it on once it has been stable long enough
`default_nettype none

module aon_glitch_filter #(
  parameter int Cycles = usb_aon_timing_pkg::EventFilterCycles
) (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  input  wire logic cond_i,
  output logic      filt_o
);

  import usb_aon_timing_pkg::*;

  // The counter must be able to hold Cycles itself
  localparam int unsigned CntW = $clog2(Cycles + 1);
  // Count of earlier equal samples at which one more equal sample is enough
  localparam logic [CntW-1:0] CntLast = CntW'(Cycles - 1);

  logic [SyncStages-1:0] sync_q;
  logic                  sync_val;
  logic                  stored_q;
  logic [CntW-1:0]       cnt_q;
  logic                  filt_q;

  // Oldest synchronizer stage is the first one that is safe to use
  assign sync_val = sync_q[SyncStages-1];

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q   <= '0;
      stored_q <= 1'b0;
      cnt_q    <= '0;
      filt_q   <= 1'b0;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], cond_i};
      if (sync_val != stored_q) begin
        // A new level restarts the run of equal samples
        stored_q <= sync_val;
        cnt_q    <= CntW'(1);
      end else begin
        if (cnt_q < CntW'(Cycles)) begin
          cnt_q <= cnt_q + CntW'(1);
        end
        // This sample completes Cycles equal samples in a row
        if (cnt_q >= CntLast) begin
          filt_q <= sync_val;
        end
      end
    end
  end

  assign filt_o = filt_q;

endmodule : aon_glitch_filter

`default_nettype wire

// ==== hw/aon_line_monitor.sv ====
// Input side of the wake detector that derives raw line conditions and debounces each of them
`default_nettype none

module aon_line_monitor (
  input  wire logic                         clk_aon_i,
  input  wire logic                         rst_aon_ni,
  input  wire logic                         usb_dp_i,
  input  wire logic                         usb_dn_i,
  input  wire logic                         usb_sense_i,
  input  wire logic                         dppullup_en_i,
  input  wire logic                         dnpullup_en_i,
  output usb_aon_event_pkg::aon_events_t    filt_events_o
);

  import usb_aon_timing_pkg::*;
  import usb_aon_event_pkg::*;

  logic not_idle_async;
  logic se0_async;
  logic sense_lost_async;

  // In suspend the device pull-ups set the idle line level
  // Any pin that disagrees with its pull-up means the host is driving the bus
  // Comparing against the pull-ups also handles swapped D+ and D- pins
  assign not_idle_async = (usb_dp_i != dppullup_en_i) | (usb_dn_i != dnpullup_en_i);

  // Single ended zero on both lines
  assign se0_async = ~usb_dp_i & ~usb_dn_i;

  // VBUS sense is active high
  assign sense_lost_async = ~usb_sense_i;

  // The longer activity filter also gives the main block time to react
  aon_glitch_filter #(
    .Cycles (ActivityFilterCycles)
  ) u_filt_not_idle (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .cond_i     (not_idle_async),
    .filt_o     (filt_events_o[EvNotIdle])
  );

  aon_glitch_filter #(
    .Cycles (EventFilterCycles)
  ) u_filt_bus_reset (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .cond_i     (se0_async),
    .filt_o     (filt_events_o[EvBusReset])
  );

  aon_glitch_filter #(
    .Cycles (EventFilterCycles)
  ) u_filt_sense_lost (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .cond_i     (sense_lost_async),
    .filt_o     (filt_events_o[EvSenseLost])
  );

endmodule : aon_line_monitor

`default_nettype wire

// ==== hw/aon_wake_fsm.sv ====
// Wake detector FSM that tracks suspend monitoring and latches wake events into a wake request
`default_nettype none

module aon_wake_fsm (
  input  wire logic                         clk_aon_i,
  input  wire logic                         rst_aon_ni,
  input  wire logic                         suspend_req_aon_i,
  input  wire logic                         wake_ack_aon_i,
  input  usb_aon_event_pkg::aon_events_t    filt_events_i,
  output logic                              active_o,
  output usb_aon_event_pkg::aon_events_t    events_o,
  output logic                              wake_req_aon_o
);

  import usb_aon_event_pkg::*;

  typedef enum logic {
    StIdle,
    StMonitor
  } state_e;

  state_e      state_d, state_q;
  aon_events_t events_d, events_q;
  logic        wake_req_d, wake_req_q;
  logic        active_q;
  logic        active_d;

  assign active_q = (state_q == StMonitor);
  assign active_d = (state_d == StMonitor);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Main USB block owns the bus until it asks for suspend
      StIdle: begin
        if (suspend_req_aon_i) begin
          state_d = StMonitor;
        end
      end
      // Detector owns the pull-ups until software acknowledges the wake
      StMonitor: begin
        if (wake_ack_aon_i) begin
          state_d = StIdle;
        end
      end
    endcase
  end

  // Flags only collect events while monitoring and drop together with active
  assign events_d   = (active_q && active_d) ? (events_q | filt_events_i) : NoEvents;
  assign wake_req_d = |events_d;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q    <= StIdle;
      events_q   <= NoEvents;
      wake_req_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      events_q   <= events_d;
      wake_req_q <= wake_req_d;
    end
  end

  assign active_o       = active_q;
  assign events_o       = events_q;
  assign wake_req_aon_o = wake_req_q;

endmodule : aon_wake_fsm

`default_nettype wire

// ==== hw/aon_pullup_hold.sv ====
// Output side of the wake detector that keeps the USB pull-ups steady while the main block sleeps
`default_nettype none

module aon_pullup_hold (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  input  wire logic active_i,
  input  wire logic usbdev_dppullup_en_i,
  input  wire logic usbdev_dnpullup_en_i,
  output logic      usb_dppullup_en_o,
  output logic      usb_dnpullup_en_o
);

  import usb_aon_timing_pkg::*;

  // Bit 1 carries D+ and bit 0 carries D-
  logic [SyncStages-1:0][1:0] sync_q;
  logic [1:0]                 pullup_aon;
  logic [1:0]                 held_d, held_q;

  // Oldest stage holds the enables in the always-on domain
  assign pullup_aon = sync_q[SyncStages-1];

  // The held copy tracks the main block until monitoring starts, then freezes
  assign held_d = active_i ? held_q : pullup_aon;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q <= '0;
      held_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], {usbdev_dppullup_en_i, usbdev_dnpullup_en_i}};
      held_q <= held_d;
    end
  end

  // When inactive the main block drives the pins directly with no added delay
  // When active the frozen copy keeps the bus in its suspend state even
  // after the main block loses power
  assign usb_dppullup_en_o = active_i ? held_q[1] : usbdev_dppullup_en_i;
  assign usb_dnpullup_en_o = active_i ? held_q[0] : usbdev_dnpullup_en_i;

endmodule : aon_pullup_hold

`default_nettype wire

// ==== hw/usb_aon_wake_top.sv ====
// Top level of the always-on USB wake detector that joins line monitor, wake FSM and pull-up hold
`default_nettype none

module usb_aon_wake_top (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  input  wire logic usb_dp_i,
  input  wire logic usb_dn_i,
  input  wire logic usb_sense_i,
  input  wire logic usbdev_dppullup_en_i,
  input  wire logic usbdev_dnpullup_en_i,
  input  wire logic suspend_req_aon_i,
  input  wire logic wake_ack_aon_i,
  output logic      usb_dppullup_en_o,
  output logic      usb_dnpullup_en_o,
  output logic      wake_req_aon_o,
  output logic      bus_not_idle_aon_o,
  output logic      bus_reset_aon_o,
  output logic      sense_lost_aon_o,
  output logic      wake_detect_active_aon_o
);

  import usb_aon_event_pkg::*;

  aon_events_t filt_events;
  aon_events_t events;
  logic        active;

  // The pull-up outputs double as the expected idle level of the line
  aon_line_monitor u_line_monitor (
    .clk_aon_i     (clk_aon_i),
    .rst_aon_ni    (rst_aon_ni),
    .usb_dp_i      (usb_dp_i),
    .usb_dn_i      (usb_dn_i),
    .usb_sense_i   (usb_sense_i),
    .dppullup_en_i (usb_dppullup_en_o),
    .dnpullup_en_i (usb_dnpullup_en_o),
    .filt_events_o (filt_events)
  );

  aon_wake_fsm u_wake_fsm (
    .clk_aon_i         (clk_aon_i),
    .rst_aon_ni        (rst_aon_ni),
    .suspend_req_aon_i (suspend_req_aon_i),
    .wake_ack_aon_i    (wake_ack_aon_i),
    .filt_events_i     (filt_events),
    .active_o          (active),
    .events_o          (events),
    .wake_req_aon_o    (wake_req_aon_o)
  );

  aon_pullup_hold u_pullup_hold (
    .clk_aon_i            (clk_aon_i),
    .rst_aon_ni           (rst_aon_ni),
    .active_i             (active),
    .usbdev_dppullup_en_i (usbdev_dppullup_en_i),
    .usbdev_dnpullup_en_i (usbdev_dnpullup_en_i),
    .usb_dppullup_en_o    (usb_dppullup_en_o),
    .usb_dnpullup_en_o    (usb_dnpullup_en_o)
  );

  // Software reads each wake cause as its own flag
  assign bus_not_idle_aon_o       = events[EvNotIdle];
  assign bus_reset_aon_o          = events[EvBusReset];
  assign sense_lost_aon_o         = events[EvSenseLost];
  assign wake_detect_active_aon_o = active;

endmodule : usb_aon_wake_top

`default_nettype wire

// ==== dv/aon_wake_asserts.sv ====
// Assertions on the wake FSM invariants that are bound into every instance of the FSM
`default_nettype none

module aon_wake_asserts (
  input wire logic                         clk_aon_i,
  input wire logic                         rst_aon_ni,
  input wire logic                         active_o,
  input usb_aon_event_pkg::aon_events_t    events_o,
  input wire logic                         wake_req_aon_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import usb_aon_event_pkg::*;

  // A wake request only exists while the detector owns the bus
  wake_req_needs_active: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    wake_req_aon_o |-> active_o)
    else $error("wake request raised while the detector is inactive");

  // Flags drop on the same edge as active
  flags_clear_when_idle: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !active_o |-> (events_o == NoEvents))
    else $error("event flags set while the detector is inactive");

  active_known: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !$isunknown(active_o))
    else $error("active state is unknown after reset");

endmodule : aon_wake_asserts

bind aon_wake_fsm aon_wake_asserts u_wake_asserts (
  .clk_aon_i      (clk_aon_i),
  .rst_aon_ni     (rst_aon_ni),
  .active_o       (active_o),
  .events_o       (events_o),
  .wake_req_aon_o (wake_req_aon_o)
);

`default_nettype wire

// ==== dv/aon_wake_checker.sv ====
// Checker that compares the wake detector outputs with the trace values and counts mismatches
`default_nettype none

module aon_wake_checker (
  input  wire logic                         clk_aon_i,
  input  wire logic                         chk_en_i,
  input  wire logic                         exp_dppullup_en_i,
  input  wire logic                         exp_dnpullup_en_i,
  input  wire logic                         exp_wake_req_i,
  input  usb_aon_event_pkg::aon_events_t    exp_events_i,
  input  wire logic                         exp_active_i,
  input  wire logic                         act_dppullup_en_i,
  input  wire logic                         act_dnpullup_en_i,
  input  wire logic                         act_wake_req_i,
  input  wire logic                         act_not_idle_i,
  input  wire logic                         act_bus_reset_i,
  input  wire logic                         act_sense_lost_i,
  input  wire logic                         act_active_i,
  output int                                err_cnt_o,
  output int                                chk_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import usb_aon_event_pkg::*;

  int          err_cnt = 0;
  int          chk_cnt = 0;
  aon_events_t act_events;

  // Rebuild the flag vector so it lines up with the expected bundle
  assign act_events[EvNotIdle]   = act_not_idle_i;
  assign act_events[EvBusReset]  = act_bus_reset_i;
  assign act_events[EvSenseLost] = act_sense_lost_i;

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("error t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Outputs are sampled on the rising edge, half a cycle after the inputs moved
  always @(posedge clk_aon_i) begin
    if (chk_en_i) begin
      chk_cnt++;
      compare_bit("usb_dppullup_en_o", exp_dppullup_en_i, act_dppullup_en_i);
      compare_bit("usb_dnpullup_en_o", exp_dnpullup_en_i, act_dnpullup_en_i);
      compare_bit("wake_req_aon_o", exp_wake_req_i, act_wake_req_i);
      compare_bit("bus_not_idle_aon_o", exp_events_i[EvNotIdle], act_events[EvNotIdle]);
      compare_bit("bus_reset_aon_o", exp_events_i[EvBusReset], act_events[EvBusReset]);
      compare_bit("sense_lost_aon_o", exp_events_i[EvSenseLost], act_events[EvSenseLost]);
      compare_bit("wake_detect_active_aon_o", exp_active_i, act_active_i);
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule : aon_wake_checker

`default_nettype wire

// ==== dv/tb_usb_aon_wake.sv ====
// Testbench top for the USB always-on wake detector that replays the trace file against the DUT
`default_nettype none

module tb_usb_aon_wake;
  timeunit 1ns;
  timeprecision 100ps;

  import usb_aon_timing_pkg::*;
  import usb_aon_event_pkg::*;

  localparam int ResetCycles = 4;
  // Shortest hold after which every filtered level has settled
  localparam int MinHold = MaxFilterLatency + 2;

  logic clk_aon;
  logic rst_aon_n;
  logic usb_dp, usb_dn, usb_sense;
  logic usbdev_dppullup_en, usbdev_dnpullup_en;
  logic suspend_req, wake_ack;
  logic usb_dppullup_en, usb_dnpullup_en;
  logic wake_req, bus_not_idle, bus_reset, sense_lost, active;

  // Expected values handed to the checker at the end of each hold
  logic        chk_en;
  logic        exp_dppullup_en, exp_dnpullup_en, exp_wake_req, exp_active;
  aon_events_t exp_events;
  int          err_cnt, chk_cnt;

  // One entry per trace line
  int         hold_q[$];
  logic [6:0] stim_q[$];
  logic [6:0] exp_q[$];
  int         cycle_cnt;
  int         cycle_limit;

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  usb_aon_wake_top uut (
    .clk_aon_i                (clk_aon),
    .rst_aon_ni               (rst_aon_n),
    .usb_dp_i                 (usb_dp),
    .usb_dn_i                 (usb_dn),
    .usb_sense_i              (usb_sense),
    .usbdev_dppullup_en_i     (usbdev_dppullup_en),
    .usbdev_dnpullup_en_i     (usbdev_dnpullup_en),
    .suspend_req_aon_i        (suspend_req),
    .wake_ack_aon_i           (wake_ack),
    .usb_dppullup_en_o        (usb_dppullup_en),
    .usb_dnpullup_en_o        (usb_dnpullup_en),
    .wake_req_aon_o           (wake_req),
    .bus_not_idle_aon_o       (bus_not_idle),
    .bus_reset_aon_o          (bus_reset),
    .sense_lost_aon_o         (sense_lost),
    .wake_detect_active_aon_o (active)
  );

  aon_wake_checker u_checker (
    .clk_aon_i         (clk_aon),
    .chk_en_i          (chk_en),
    .exp_dppullup_en_i (exp_dppullup_en),
    .exp_dnpullup_en_i (exp_dnpullup_en),
    .exp_wake_req_i    (exp_wake_req),
    .exp_events_i      (exp_events),
    .exp_active_i      (exp_active),
    .act_dppullup_en_i (usb_dppullup_en),
    .act_dnpullup_en_i (usb_dnpullup_en),
    .act_wake_req_i    (wake_req),
    .act_not_idle_i    (bus_not_idle),
    .act_bus_reset_i   (bus_reset),
    .act_sense_lost_i  (sense_lost),
    .act_active_i      (active),
    .err_cnt_o         (err_cnt),
    .chk_cnt_o         (chk_cnt)
  );

  // Reads every step of the trace and skips comment lines that start with a hash
  task automatic read_trace(output bit ok);
    int    fd;
    int    n;
    string line;
    int    f[15];
    fd = $fopen("dv/aon_wake_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (line.len() > 0 && line[0] != "#" && n == 15) begin
          hold_q.push_back(f[0]);
          stim_q.push_back({f[1][0], f[2][0], f[3][0], f[4][0], f[5][0], f[6][0], f[7][0]});
          exp_q.push_back({f[8][0], f[9][0], f[10][0], f[11][0], f[12][0], f[13][0], f[14][0]});
        end
      end
      $fclose(fd);
    end
  endtask

  // Applies one step on the current falling edge and arms the check at its end
  task automatic run_step(input int idx);
    logic [6:0] s;
    logic [6:0] e;
    s = stim_q[idx];
    e = exp_q[idx];
    {usb_dp, usb_dn, usb_sense, usbdev_dppullup_en, usbdev_dnpullup_en} = s[6:2];
    {suspend_req, wake_ack} = s[1:0];
    chk_en = 1'b0;
    repeat (hold_q[idx] - 1) @(negedge clk_aon);
    exp_dppullup_en          = e[6];
    exp_dnpullup_en          = e[5];
    exp_wake_req             = e[4];
    exp_events[EvNotIdle]    = e[3];
    exp_events[EvBusReset]   = e[2];
    exp_events[EvSenseLost]  = e[1];
    exp_active               = e[0];
    chk_en                   = 1'b1;
    @(negedge clk_aon);
  endtask

  // Run limit is set from the summed trace holds once the trace is loaded
  always @(posedge clk_aon) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the trace did not finish", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    bit ok;
    int total;
    int short_steps;
    cycle_cnt          = 0;
    cycle_limit        = 1000000;
    rst_aon_n          = 1'b0;
    usb_dp             = 1'b1;
    usb_dn             = 1'b0;
    usb_sense          = 1'b1;
    usbdev_dppullup_en = 1'b1;
    usbdev_dnpullup_en = 1'b0;
    suspend_req        = 1'b0;
    wake_ack           = 1'b0;
    chk_en             = 1'b0;
    exp_dppullup_en    = 1'b0;
    exp_dnpullup_en    = 1'b0;
    exp_wake_req       = 1'b0;
    exp_events         = NoEvents;
    exp_active         = 1'b0;
    read_trace(ok);
    if (!ok || hold_q.size() == 0) begin
      $display("trace file dv/aon_wake_trace.txt could not be opened or holds no steps");
      $display("test failed");
      $finish;
    end else begin
      total       = 0;
      short_steps = 0;
      foreach (hold_q[i]) begin
        total = total + hold_q[i];
        if (hold_q[i] < MinHold) begin
          short_steps++;
        end
      end
      cycle_limit = total + ResetCycles + 20;
      $display("trace has %0d steps, %0d of them are short pulses", hold_q.size(), short_steps);
      repeat (ResetCycles) @(posedge clk_aon);
      @(negedge clk_aon);
      rst_aon_n = 1'b1;
      foreach (hold_q[i]) begin
        run_step(i);
      end
      chk_en = 1'b0;
      if (chk_cnt != hold_q.size()) begin
        $display("only %0d of %0d trace steps reached the checker", chk_cnt, hold_q.size());
      end
      $display("checks %0d errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt == hold_q.size()) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule : tb_usb_aon_wake

`default_nettype wire

// ==== dv/aon_wake_trace.txt ====
# hold dp dn sense pu_dp_in pu_dn_in suspend ack | expected:
# pu_dp_out pu_dn_out wake_req not_idle bus_reset sense_lost active
10 1 0 1 0 0 0 0 0 0 0 0 0 0 0
10 1 0 1 0 1 0 0 0 1 0 0 0 0 0
10 1 0 1 1 1 0 0 1 1 0 0 0 0 0
10 1 0 1 1 0 0 0 1 0 0 0 0 0 0
10 1 0 0 1 0 0 0 1 0 0 0 0 0 0
10 1 0 1 1 0 0 0 1 0 0 0 0 0 0
10 1 0 1 1 0 1 0 1 0 0 0 0 0 1
10 1 0 1 0 1 1 0 1 0 0 0 0 0 1
10 1 0 1 0 1 0 0 1 0 0 0 0 0 1
10 1 0 1 0 0 0 0 1 0 0 0 0 0 1
10 0 1 1 0 0 0 0 1 0 1 1 0 0 1
10 1 0 1 0 0 0 0 1 0 1 1 0 0 1
10 1 0 1 0 0 0 1 0 0 0 0 0 0 0
10 1 0 1 1 0 0 0 1 0 0 0 0 0 0
10 1 0 1 1 0 1 0 1 0 0 0 0 0 1
10 1 0 1 1 0 0 0 1 0 0 0 0 0 1
1 0 0 1 1 0 0 0 1 0 0 0 0 0 1
10 1 0 1 1 0 0 0 1 0 0 0 0 0 1
10 0 0 1 1 0 0 0 1 0 1 1 1 0 1
10 1 0 1 1 0 0 0 1 0 1 1 1 0 1
10 1 0 1 1 0 0 1 1 0 0 0 0 0 0
10 1 0 1 1 0 0 0 1 0 0 0 0 0 0
10 1 0 1 1 0 1 0 1 0 0 0 0 0 1
10 1 0 0 1 0 0 0 1 0 1 0 0 1 1
10 1 0 1 1 0 0 0 1 0 1 0 0 1 1
10 1 0 1 0 1 0 1 0 1 0 0 0 0 0
10 1 0 1 1 1 0 0 1 1 0 0 0 0 0

// ==== compile.f ====
hw/usb_aon_timing_pkg.sv
hw/usb_aon_event_pkg.sv
hw/aon_glitch_filter.sv
hw/aon_line_monitor.sv
hw/aon_wake_fsm.sv
hw/aon_pullup_hold.sv
hw/usb_aon_wake_top.sv
dv/aon_wake_asserts.sv
dv/aon_wake_checker.sv
dv/tb_usb_aon_wake.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_usb_aon_wake \
  && ./obj_dir/Vtb_usb_aon_wake > sim.log 2>&1 \
  || echo "build or simulation aborted" >> sim.log
cat sim.log
! grep -q "test failed" sim.log && grep -q "test passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
